//--- source/pipeCtrl_consts.svh
`ifndef PIPECTRL_CONSTS_SVH
`define PIPECTRL_CONSTS_SVH

// word address and data widths
`define ADDR_W 8
`define DATA_W 32

// shared memory depth in words
`define MEM_WORDS 256

// cycles from bus request strobe to bus done pulse
`define MEM_LATENCY 3

`endif

//--- source/pipeCtrlPkg.sv
package pipeCtrlPkg;

    // data port operation
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } memOpT;

    // owner of the transaction on the shared bus
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_FETCH = 2'd1,
        OWN_DATA  = 2'd2
    } busOwnerT;

    // winning hazard cause, highest priority first
    typedef enum logic [3:0] {
        CAUSE_NONE, CAUSE_EXCPW, CAUSE_MEMWAIT, CAUSE_EXCPM, CAUSE_BRANCH,
        CAUSE_EWAIT, CAUSE_JR, CAUSE_OVERFLOW, CAUSE_IWAIT
    } hazardCauseT;

endpackage

//--- source/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit import pipeCtrlPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic i_branchM,
    input  logic i_iWait,
    input  logic i_dWait,
    input  logic i_eWait,
    input  logic i_overflowI,
    input  logic i_jrI,
    input  logic i_waitM,
    input  logic i_excpW,
    input  logic i_excpM,
    output logic o_stallF,
    output logic o_stallF2,
    output logic o_flushF2,
    output logic o_stallD,
    output logic o_flushD,
    output logic o_stallI,
    output logic o_stallIDe,
    output logic o_flushI,
    output logic o_flushQue,
    output logic o_stallE,
    output logic o_flushE,
    output logic o_stallM,
    output logic o_flushM,
    output logic o_stallM2,
    output logic o_flushM2,
    output logic o_flushM3,
    output logic o_flushW,
    output logic o_predFlushQue
);

    hazardCauseT cause;
    logic        memWait;
    logic        redirect;
    logic        fetchKill;
    logic        fetchKillNxt;

    assign memWait = i_dWait | i_waitM;

    // a fetch still in flight when a redirect hits must be dropped on return
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchKill <= 1'b0;
        end else begin
            fetchKill <= fetchKillNxt;
        end
    end

    // fixed priority
    always_comb begin
        if (i_excpW) begin
            cause = CAUSE_EXCPW;
        end else if (memWait) begin
            cause = CAUSE_MEMWAIT;
        end else if (i_excpM) begin
            cause = CAUSE_EXCPM;
        end else if (i_branchM) begin
            cause = CAUSE_BRANCH;
        end else if (i_eWait) begin
            cause = CAUSE_EWAIT;
        end else if (i_jrI) begin
            cause = CAUSE_JR;
        end else if (i_overflowI) begin
            cause = CAUSE_OVERFLOW;
        end else if (i_iWait) begin
            cause = CAUSE_IWAIT;
        end else begin
            cause = CAUSE_NONE;
        end
    end

    always_comb begin
        o_stallF = 1'b0;
        o_stallF2 = 1'b0;
        o_flushF2 = 1'b0;
        o_stallD = 1'b0;
        o_flushD = 1'b0;
        o_stallI = 1'b0;
        o_stallIDe = 1'b0;
        o_flushI = 1'b0;
        o_flushQue = 1'b0;
        o_stallE = 1'b0;
        o_flushE = 1'b0;
        o_stallM = 1'b0;
        o_flushM = 1'b0;
        o_stallM2 = 1'b0;
        o_flushM2 = 1'b0;
        o_flushM3 = 1'b0;
        o_flushW = 1'b0;
        o_predFlushQue = 1'b0;
        redirect = 1'b0;
        fetchKillNxt = fetchKill;

        case (cause)
            CAUSE_EXCPW: begin
                {o_flushF2, o_flushD, o_flushI, o_flushE, o_flushM} = '1;
                {o_flushM2, o_flushM3, o_flushW, o_flushQue} = '1;
                redirect = 1'b1;
            end
            CAUSE_MEMWAIT: begin
                {o_stallF, o_stallF2, o_stallD, o_stallI, o_stallIDe} = '1;
                {o_stallE, o_stallM, o_stallM2, o_flushM3} = '1;
            end
            CAUSE_EXCPM, CAUSE_BRANCH: begin
                {o_flushF2, o_flushD, o_flushI, o_flushE, o_flushM} = '1;
                o_flushQue = 1'b1;
                redirect = 1'b1;
            end
            CAUSE_EWAIT: begin
                {o_stallF, o_stallF2, o_stallD, o_stallI, o_stallIDe} = '1;
                {o_stallE, o_flushM} = '1;
            end
            CAUSE_JR: begin
                {o_flushF2, o_flushD, o_flushI, o_predFlushQue} = '1;
                redirect = 1'b1;
            end
            CAUSE_OVERFLOW: begin
                {o_stallF, o_stallF2, o_stallI, o_stallD} = '1;
            end
            CAUSE_IWAIT: begin
                {o_stallF, o_flushF2} = '1;
            end
            default: begin
            end
        endcase

        // hold F until the stale fetch lands
        if (redirect && i_iWait) begin
            o_stallF = 1'b1;
            fetchKillNxt = 1'b1;
        end

        // stale fetch arrives, kill it in F2
        if (!o_stallF && fetchKill) begin
            o_flushF2 = 1'b1;
            fetchKillNxt = 1'b0;
        end
    end

    aStallFlushD: assert property (@(posedge clk) disable iff (reset)
        !(o_stallD && o_flushD));

endmodule

//--- source/busArbiter.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module busArbiter import pipeCtrlPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_fetchPending,
    input  logic [`ADDR_W-1:0] i_fetchAddr,
    output logic               o_fetchDone,
    output logic [`DATA_W-1:0] o_fetchData,
    input  logic               i_dataPending,
    input  memOpT              i_dataOp,
    input  logic [`ADDR_W-1:0] i_dataAddr,
    input  logic [`DATA_W-1:0] i_dataWdata,
    output logic               o_dataDone,
    output logic [`DATA_W-1:0] o_dataRdata,
    output logic               o_busReq,
    output logic [`ADDR_W-1:0] o_busAddr,
    output logic               o_busWe,
    output logic [`DATA_W-1:0] o_busWdata,
    output busOwnerT           o_busOwner,
    input  logic               i_busDone,
    input  logic [`DATA_W-1:0] i_busRdata
);

    busOwnerT owner;
    logic     idle;
    logic     contended;
    logic     grantData;
    logic     grantFetch;
    logic     lastData;

    assign idle = (owner == OWN_NONE);
    assign contended = i_fetchPending & i_dataPending;

    // data wins the first tie and later ties alternate
    assign grantData = idle & i_dataPending & (~i_fetchPending | ~lastData);
    assign grantFetch = idle & i_fetchPending & ~grantData;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= OWN_NONE;
            o_busReq <= 1'b0;
            lastData <= 1'b0;
        end else begin
            o_busReq <= grantData | grantFetch;
            if (grantData) begin
                owner <= OWN_DATA;
            end else if (grantFetch) begin
                owner <= OWN_FETCH;
            end else if (i_busDone) begin
                owner <= OWN_NONE;
            end
            if (contended && idle) begin
                lastData <= grantData;
            end
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (grantData) begin
            o_busAddr <= i_dataAddr;
            o_busWe <= (i_dataOp == MEM_STORE);
            o_busWdata <= i_dataWdata;
        end else if (grantFetch) begin
            o_busAddr <= i_fetchAddr;
            o_busWe <= 1'b0;
        end
    end

    assign o_busOwner = owner;

    // return routing
    assign o_fetchDone = i_busDone & (owner == OWN_FETCH);
    assign o_dataDone = i_busDone & (owner == OWN_DATA);
    assign o_fetchData = i_busRdata;
    assign o_dataRdata = i_busRdata;

    // memory answers each request after the fixed latency
    aDoneOnTime: assert property (@(posedge clk) disable iff (reset)
        i_busDone |-> $past(o_busReq, `MEM_LATENCY));

    aOneDone: assert property (@(posedge clk) disable iff (reset)
        i_busDone |-> (o_fetchDone ^ o_dataDone));

endmodule

//--- source/fetchPort.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module fetchPort (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_fetchReq,
    input  logic [`ADDR_W-1:0] i_fetchAddr,
    output logic               o_iWait,
    output logic               o_fetchValid,
    output logic [`DATA_W-1:0] o_instr,
    output logic               o_pending,
    output logic [`ADDR_W-1:0] o_addr,
    input  logic               i_done,
    input  logic [`DATA_W-1:0] i_data
);

    logic pending;
    logic accept;

    // one read at a time
    assign accept = i_fetchReq & ~pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (i_done) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_addr <= i_fetchAddr;
        end
    end

    assign o_pending = pending;

    // wait covers the done cycle too
    assign o_iWait = pending;

    assign o_fetchValid = pending & i_done;
    assign o_instr = i_data;

endmodule

//--- source/dataPort.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module dataPort import pipeCtrlPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_memReq,
    input  memOpT              i_memOp,
    input  logic [`ADDR_W-1:0] i_memAddr,
    input  logic [`DATA_W-1:0] i_memWdata,
    output logic               o_dWait,
    output logic               o_memDone,
    output logic [`DATA_W-1:0] o_loadData,
    output logic               o_pending,
    output memOpT              o_op,
    output logic [`ADDR_W-1:0] o_addr,
    output logic [`DATA_W-1:0] o_wdata,
    input  logic               i_done,
    input  logic [`DATA_W-1:0] i_rdata
);

    logic pending;
    logic accept;

    assign accept = i_memReq & ~pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (i_done) begin
            pending <= 1'b0;
        end
    end

    // op, address and store data held until done
    always_ff @(posedge clk) begin
        if (accept) begin
            o_op <= i_memOp;
            o_addr <= i_memAddr;
            o_wdata <= i_memWdata;
        end
    end

    assign o_pending = pending;
    assign o_dWait = pending;

    // store completion pulses too, data ignored
    assign o_memDone = pending & i_done;
    assign o_loadData = i_rdata;

    aOpValid: assert property (@(posedge clk) disable iff (reset)
        i_memReq |-> i_memOp != MEM_NONE);

endmodule

//--- source/sharedMem.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module sharedMem import pipeCtrlPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_busReq,
    input  logic [`ADDR_W-1:0] i_busAddr,
    input  logic               i_busWe,
    input  logic [`DATA_W-1:0] i_busWdata,
    input  busOwnerT           i_busOwner,
    output logic               o_busDone,
    output logic [`DATA_W-1:0] o_busRdata
);

    localparam int CntW = $clog2(`MEM_LATENCY + 1);

    logic [`DATA_W-1:0] mem [`MEM_WORDS];
    logic               busy;
    logic [CntW-1:0]    cnt;
    logic [`ADDR_W-1:0] addrQ;
    logic               weQ;
    logic [`DATA_W-1:0] wdataQ;

    // done lands MEM_LATENCY cycles after the strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt <= '0;
        end else if (i_busReq) begin
            busy <= 1'b1;
            cnt <= CntW'(`MEM_LATENCY - 1);
        end else if (o_busDone) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_busReq) begin
            addrQ <= i_busAddr;
            weQ <= i_busWe;
            wdataQ <= i_busWdata;
        end
        if (o_busDone && weQ) begin
            mem[addrQ] <= wdataQ;
        end
    end

    assign o_busDone = busy & (cnt == '0);
    assign o_busRdata = mem[addrQ];

    aOwnerNamed: assert property (@(posedge clk) disable iff (reset)
        i_busReq |-> i_busOwner != OWN_NONE);

endmodule

//--- source/pipeCtrlTop.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module pipeCtrlTop import pipeCtrlPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_fetchReq,
    input  logic [`ADDR_W-1:0] i_fetchAddr,
    output logic               o_fetchValid,
    output logic [`DATA_W-1:0] o_instr,
    input  logic               i_memReq,
    input  memOpT              i_memOp,
    input  logic [`ADDR_W-1:0] i_memAddr,
    input  logic [`DATA_W-1:0] i_memWdata,
    output logic               o_memDone,
    output logic [`DATA_W-1:0] o_loadData,
    input  logic               i_branchM,
    input  logic               i_eWait,
    input  logic               i_overflowI,
    input  logic               i_jrI,
    input  logic               i_waitM,
    input  logic               i_excpW,
    input  logic               i_excpM,
    output logic               o_stallF,
    output logic               o_stallF2,
    output logic               o_flushF2,
    output logic               o_stallD,
    output logic               o_flushD,
    output logic               o_stallI,
    output logic               o_stallIDe,
    output logic               o_flushI,
    output logic               o_flushQue,
    output logic               o_stallE,
    output logic               o_flushE,
    output logic               o_stallM,
    output logic               o_flushM,
    output logic               o_stallM2,
    output logic               o_flushM2,
    output logic               o_flushM3,
    output logic               o_flushW,
    output logic               o_predFlushQue,
    output logic               o_iWait,
    output logic               o_dWait
);

    logic               fetchPending;
    logic [`ADDR_W-1:0] fetchAddr;
    logic               fetchDone;
    logic [`DATA_W-1:0] fetchData;
    logic               dataPending;
    memOpT              dataOp;
    logic [`ADDR_W-1:0] dataAddr;
    logic [`DATA_W-1:0] dataWdata;
    logic               dataDone;
    logic [`DATA_W-1:0] dataRdata;
    logic               busReq;
    logic [`ADDR_W-1:0] busAddr;
    logic               busWe;
    logic [`DATA_W-1:0] busWdata;
    busOwnerT           busOwner;
    logic               busDone;
    logic [`DATA_W-1:0] busRdata;

    fetchPort uFetch (
        .clk(clk), .reset(reset),
        .i_fetchReq(i_fetchReq), .i_fetchAddr(i_fetchAddr),
        .o_iWait(o_iWait), .o_fetchValid(o_fetchValid), .o_instr(o_instr),
        .o_pending(fetchPending), .o_addr(fetchAddr),
        .i_done(fetchDone), .i_data(fetchData)
    );

    dataPort uData (
        .clk(clk), .reset(reset),
        .i_memReq(i_memReq), .i_memOp(i_memOp),
        .i_memAddr(i_memAddr), .i_memWdata(i_memWdata),
        .o_dWait(o_dWait), .o_memDone(o_memDone), .o_loadData(o_loadData),
        .o_pending(dataPending), .o_op(dataOp),
        .o_addr(dataAddr), .o_wdata(dataWdata),
        .i_done(dataDone), .i_rdata(dataRdata)
    );

    busArbiter uArb (
        .clk(clk), .reset(reset),
        .i_fetchPending(fetchPending), .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchData(fetchData),
        .i_dataPending(dataPending), .i_dataOp(dataOp),
        .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_dataDone(dataDone), .o_dataRdata(dataRdata),
        .o_busReq(busReq), .o_busAddr(busAddr), .o_busWe(busWe),
        .o_busWdata(busWdata), .o_busOwner(busOwner),
        .i_busDone(busDone), .i_busRdata(busRdata)
    );

    sharedMem uMem (
        .clk(clk), .reset(reset),
        .i_busReq(busReq), .i_busAddr(busAddr), .i_busWe(busWe),
        .i_busWdata(busWdata), .i_busOwner(busOwner),
        .o_busDone(busDone), .o_busRdata(busRdata)
    );

    // waits from the two ports feed the hazard priority
    hazardUnit uHazard (
        .clk(clk), .reset(reset),
        .i_branchM(i_branchM), .i_iWait(o_iWait), .i_dWait(o_dWait),
        .i_eWait(i_eWait), .i_overflowI(i_overflowI), .i_jrI(i_jrI),
        .i_waitM(i_waitM), .i_excpW(i_excpW), .i_excpM(i_excpM),
        .o_stallF(o_stallF), .o_stallF2(o_stallF2), .o_flushF2(o_flushF2),
        .o_stallD(o_stallD), .o_flushD(o_flushD), .o_stallI(o_stallI),
        .o_stallIDe(o_stallIDe), .o_flushI(o_flushI), .o_flushQue(o_flushQue),
        .o_stallE(o_stallE), .o_flushE(o_flushE), .o_stallM(o_stallM),
        .o_flushM(o_flushM), .o_stallM2(o_stallM2), .o_flushM2(o_flushM2),
        .o_flushM3(o_flushM3), .o_flushW(o_flushW),
        .o_predFlushQue(o_predFlushQue)
    );

endmodule

//--- tests/pipeCtrlTb.sv
`timescale 1ns/1ns
`include "pipeCtrl_consts.svh"

module pipeCtrlTb import pipeCtrlPkg::*; ();

    // reset, six memory round trips with slack, cause checks, then margin
    localparam int cycleLimit = 4 + 6 * (`MEM_LATENCY + 4) + 20 + 100;

    logic               clk;
    logic               reset;
    logic               fetchReq;
    logic [`ADDR_W-1:0] fetchAddr;
    logic               fetchValid;
    logic [`DATA_W-1:0] instr;
    logic               memReq;
    memOpT              memOp;
    logic [`ADDR_W-1:0] memAddr;
    logic [`DATA_W-1:0] memWdata;
    logic               memDone;
    logic [`DATA_W-1:0] loadData;
    logic               branchM;
    logic               eWait;
    logic               overflowI;
    logic               jrI;
    logic               waitM;
    logic               excpW;
    logic               excpM;
    logic               iWait;
    logic               dWait;
    logic [17:0]        hz;
    logic               stallF;
    logic               flushF2;

    // bit order of hz
    string hzNames [18] = '{
        "stallF", "stallF2", "flushF2", "stallD", "flushD", "stallI",
        "stallIDe", "flushI", "flushQue", "stallE", "flushE", "stallM",
        "flushM", "stallM2", "flushM2", "flushM3", "flushW", "predFlushQue"
    };

    logic [`DATA_W-1:0] model [logic [`ADDR_W-1:0]];
    logic [`ADDR_W-1:0] storedAddr;
    logic [17:0]        memWaitExp;
    logic [17:0]        allFlushExp;
    integer             seed = 32'h523b;
    int                 errorCount = 0;
    int                 checkCount = 0;
    int                 cycleCount = 0;

    assign stallF = hz[0];
    assign flushF2 = hz[2];

    pipeCtrlTop UUT (
        .clk(clk), .reset(reset),
        .i_fetchReq(fetchReq), .i_fetchAddr(fetchAddr),
        .o_fetchValid(fetchValid), .o_instr(instr),
        .i_memReq(memReq), .i_memOp(memOp), .i_memAddr(memAddr), .i_memWdata(memWdata),
        .o_memDone(memDone), .o_loadData(loadData),
        .i_branchM(branchM), .i_eWait(eWait), .i_overflowI(overflowI), .i_jrI(jrI),
        .i_waitM(waitM), .i_excpW(excpW), .i_excpM(excpM),
        .o_stallF(hz[0]), .o_stallF2(hz[1]), .o_flushF2(hz[2]), .o_stallD(hz[3]),
        .o_flushD(hz[4]), .o_stallI(hz[5]), .o_stallIDe(hz[6]), .o_flushI(hz[7]),
        .o_flushQue(hz[8]), .o_stallE(hz[9]), .o_flushE(hz[10]), .o_stallM(hz[11]),
        .o_flushM(hz[12]), .o_stallM2(hz[13]), .o_flushM2(hz[14]), .o_flushM3(hz[15]),
        .o_flushW(hz[16]), .o_predFlushQue(hz[17]),
        .o_iWait(iWait), .o_dWait(dWait)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic [17:0] maskOf(input string name);
        logic [17:0] m;
        int          i;
        m = '0;
        for (i = 0; i < 18; i++) begin
            if (hzNames[i] == name) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

    task automatic checkHazard(input logic [17:0] exp);
        int i;
        for (i = 0; i < 18; i++) begin
            checkValue(hzNames[i], 32'(hz[i]), 32'(exp[i]));
        end
    endtask

    function automatic logic [`ADDR_W-1:0] randAddr();
        logic [31:0] r;
        r = $random(seed);
        return r[`ADDR_W-1:0];
    endfunction

    task automatic driveData(input memOpT op, input logic [`ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] wdata);
        memReq = 1'b1;
        memOp = op;
        memAddr = addr;
        memWdata = wdata;
        if (op == MEM_STORE) begin
            model[addr] = wdata;
        end
    endtask

    task automatic driveFetch(input logic [`ADDR_W-1:0] addr);
        fetchReq = 1'b1;
        fetchAddr = addr;
    endtask

    // count falling edges from the strobe until each wanted completion
    task automatic waitDone(input bit wantData, input bit wantFetch,
                            output int dataAt, output int fetchAt,
                            output logic [`DATA_W-1:0] loadVal,
                            output logic [`DATA_W-1:0] instrVal);
        int cycles;
        bit dataSeen;
        bit fetchSeen;
        cycles = 0;
        dataSeen = !wantData;
        fetchSeen = !wantFetch;
        dataAt = 0;
        fetchAt = 0;
        loadVal = '0;
        instrVal = '0;
        while (!(dataSeen && fetchSeen)) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1 && wantData) begin
                checkValue("dWait", 32'(dWait), 1);
            end
            if (cycles == 1 && wantFetch) begin
                checkValue("iWait", 32'(iWait), 1);
            end
            if (dWait) begin
                checkHazard(memWaitExp);
            end
            if (memDone) begin
                dataSeen = 1'b1;
                dataAt = cycles;
                loadVal = loadData;
            end
            if (fetchValid) begin
                fetchSeen = 1'b1;
                fetchAt = cycles;
                instrVal = instr;
            end
            memReq = 1'b0;
            fetchReq = 1'b0;
        end
        // waits drop on the edge after the done pulse
        @(negedge clk);
        checkValue("dWait", 32'(dWait), 0);
        checkValue("iWait", 32'(iWait), 0);
    endtask

    task automatic storeThenLoad();
        logic [`DATA_W-1:0] data;
        logic [`DATA_W-1:0] loadVal;
        logic [`DATA_W-1:0] instrVal;
        int                 dataAt;
        int                 fetchAt;
        storedAddr = randAddr();
        data = $random(seed);
        @(negedge clk);
        driveData(MEM_STORE, storedAddr, data);
        waitDone(1'b1, 1'b0, dataAt, fetchAt, loadVal, instrVal);
        checkValue("memDone delay", dataAt, `MEM_LATENCY + 2);
        @(negedge clk);
        driveData(MEM_LOAD, storedAddr, '0);
        waitDone(1'b1, 1'b0, dataAt, fetchAt, loadVal, instrVal);
        checkValue("memDone delay", dataAt, `MEM_LATENCY + 2);
        checkValue("loadData", loadVal, model[storedAddr]);
    endtask

    task automatic fetchAndStore();
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
        logic [`DATA_W-1:0] loadVal;
        logic [`DATA_W-1:0] instrVal;
        int                 dataAt;
        int                 fetchAt;
        addr = randAddr();
        data = $random(seed);
        @(negedge clk);
        driveData(MEM_STORE, addr, data);
        driveFetch(addr);
        waitDone(1'b1, 1'b1, dataAt, fetchAt, loadVal, instrVal);
        // data takes the first tie and fetch goes once the data port lets go
        checkValue("memDone delay", dataAt, `MEM_LATENCY + 2);
        checkValue("fetchValid delay", fetchAt, 2 * (`MEM_LATENCY + 2));
        checkValue("instr", instrVal, model[addr]);
    endtask

    task automatic exceptionsUnderWait();
        logic [`DATA_W-1:0] loadVal;
        logic [`DATA_W-1:0] instrVal;
        int                 dataAt;
        int                 fetchAt;
        @(negedge clk);
        driveData(MEM_LOAD, storedAddr, '0);
        @(negedge clk);
        memReq = 1'b0;
        checkValue("dWait", 32'(dWait), 1);
        excpW = 1'b1;
        @(negedge clk);
        checkHazard(allFlushExp);
        excpW = 1'b0;
        excpM = 1'b1;
        @(negedge clk);
        // memory wait outranks excpM
        checkHazard(memWaitExp);
        excpM = 1'b0;
        waitDone(1'b1, 1'b0, dataAt, fetchAt, loadVal, instrVal);
        checkValue("loadData", loadVal, model[storedAddr]);
    endtask

    task automatic branchDuringFetch();
        @(negedge clk);
        driveFetch(storedAddr);
        @(negedge clk);
        fetchReq = 1'b0;
        checkValue("iWait", 32'(iWait), 1);
        branchM = 1'b1;
        @(negedge clk);
        checkValue("stallF", 32'(stallF), 1);
        checkValue("flushF2", 32'(flushF2), 1);
        branchM = 1'b0;
        do begin
            @(negedge clk);
        end while (!fetchValid);
        checkValue("instr", instr, model[storedAddr]);
        do begin
            @(negedge clk);
        end while (stallF);
        // stale fetch killed once in the first unstalled cycle
        checkValue("flushF2", 32'(flushF2), 1);
        @(negedge clk);
        checkValue("flushF2", 32'(flushF2), 0);
    endtask

    task automatic causeAlone(input logic [3:0] causes, input logic [17:0] exp);
        @(negedge clk);
        {eWait, jrI, overflowI, waitM} = causes;
        @(negedge clk);
        checkHazard(exp);
        {eWait, jrI, overflowI, waitM} = 4'b0000;
    endtask

    initial begin
        reset = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        memReq = 1'b0;
        memOp = MEM_NONE;
        memAddr = '0;
        memWdata = '0;
        branchM = 1'b0;
        eWait = 1'b0;
        overflowI = 1'b0;
        jrI = 1'b0;
        waitM = 1'b0;
        excpW = 1'b0;
        excpM = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        // I stage stalls both of its stall lines
        memWaitExp = maskOf("stallF") | maskOf("stallF2") | maskOf("stallD")
            | maskOf("stallI") | maskOf("stallIDe") | maskOf("stallE")
            | maskOf("stallM") | maskOf("stallM2") | maskOf("flushM3");
        allFlushExp = maskOf("flushF2") | maskOf("flushD") | maskOf("flushI")
            | maskOf("flushQue") | maskOf("flushE") | maskOf("flushM")
            | maskOf("flushM2") | maskOf("flushM3") | maskOf("flushW");
        @(negedge clk);
        checkHazard('0);
        checkValue("iWait", 32'(iWait), 0);
        checkValue("dWait", 32'(dWait), 0);
        storeThenLoad();
        fetchAndStore();
        exceptionsUnderWait();
        branchDuringFetch();
        causeAlone(4'b1000, maskOf("stallF") | maskOf("stallF2") | maskOf("stallD")
            | maskOf("stallI") | maskOf("stallIDe") | maskOf("stallE") | maskOf("flushM"));
        causeAlone(4'b0100, maskOf("flushF2") | maskOf("flushD") | maskOf("flushI")
            | maskOf("predFlushQue"));
        causeAlone(4'b0010, maskOf("stallF") | maskOf("stallF2") | maskOf("stallI")
            | maskOf("stallD"));
        // M-stage wait alone acts as a memory wait
        causeAlone(4'b0001, memWaitExp);
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/pipeCtrlPkg.sv
source/hazardUnit.sv
source/busArbiter.sv
source/fetchPort.sv
source/dataPort.sv
source/sharedMem.sv
source/pipeCtrlTop.sv
tests/pipeCtrlTb.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module pipeCtrlTb -o simv \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/simv 2>&1 | tee sim.log \
    || { echo "simulation exited with an error"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass verdict in sim.log"; exit 1; }
exit 0
